// File: source/huff_pkg.sv
`default_nettype none

package huff_pkg;

    // walk event opcodes, as posted by the host.
    typedef enum logic [1:0] {
        OP_LEAF      = 2'd0,
        OP_BACKTRACK = 2'd1,
        OP_FINISH    = 2'd2
    } walk_op_e;

    // one tree-walk step, head of the event queue.
    typedef struct packed {
        walk_op_e   op;
        logic [7:0] char_index;
    } walk_event_t;

    localparam int CODE_W = 9; // widest code word, leaf flag plus index.

    // header code word, first bit to send sits in bits[CODE_W-1].
    typedef struct packed {
        logic [CODE_W-1:0] bits;
        logic [3:0]        len;  // 1 to 9.
        logic              last; // closes the header.
    } code_word_t;

    localparam logic [3:0] LEAF_LEN      = 4'd9;
    localparam logic [3:0] BACKTRACK_LEN = 4'd1;

    // register map.
    localparam logic [3:0] EVENT_ADDR  = 4'h0;
    localparam logic [3:0] STATUS_ADDR = 4'h4;

    // event write data layout.
    localparam int EVT_OP_MSB = 9;
    localparam int EVT_OP_LSB = 8;
    localparam logic [1:0] OP_ILLEGAL = 2'd3;

    // status word layout, count lives in the low bits.
    localparam int STATUS_IDLE_BIT = 31;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: source/walk_event_regs.sv
`timescale 1ns/1ps
`default_nettype none

module walk_event_regs
    import huff_pkg::*;
#(
    parameter int EVENT_DEPTH = 4,
    parameter int COUNT_W = 16
) (
    input  wire                clk,
    input  wire                rst,
    input  wire  [3:0]         awaddr,
    input  wire                awvalid,
    output logic               awready,
    input  wire  [31:0]        wdata,
    input  wire                wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  wire                bready,
    input  wire  [3:0]         araddr,
    input  wire                arvalid,
    output logic               arready,
    output logic [31:0]        rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  wire                rready,
    output walk_event_t        evt,
    output logic               evt_valid,
    input  wire                evt_ready,
    input  wire                synth_idle,
    input  wire                ser_idle,
    input  wire  [COUNT_W-1:0] bit_count
);

    localparam int PTR_W = $clog2(EVENT_DEPTH);

    typedef enum logic {RESP_IDLE, RESP_PEND} resp_state_e;

    resp_state_e b_state;
    resp_state_e r_state;
    resp_state_e r_state_next;

    walk_event_t queue [EVENT_DEPTH];
    logic [PTR_W:0] wr_ptr; // extra msb tells full from empty.
    logic [PTR_W:0] rd_ptr;
    logic q_full;
    logic q_empty;
    logic evt_addr_hit;
    logic op_legal;
    logic wr_accept;
    logic push;
    logic ar_accept;
    logic [31:0] status_word;

    assign q_empty = (wr_ptr == rd_ptr);
    assign q_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign evt_addr_hit = (awaddr == EVENT_ADDR);
    assign op_legal     = (wdata[EVT_OP_MSB:EVT_OP_LSB] != OP_ILLEGAL);

    // only a legal event write has to wait for room.
    assign wr_accept = awvalid && wvalid && (b_state == RESP_IDLE) &&
                       !(evt_addr_hit && op_legal && q_full);
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign push      = wr_accept && evt_addr_hit && op_legal;
    assign bvalid    = (b_state == RESP_PEND);

    assign evt_valid = !q_empty;
    assign evt       = queue[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr[PTR_W-1:0]] <= '{op: walk_op_e'(wdata[EVT_OP_MSB:EVT_OP_LSB]),
                                          char_index: wdata[7:0]};
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            b_state <= RESP_IDLE;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (evt_valid && evt_ready) rd_ptr <= rd_ptr + 1'b1;
            if (wr_accept) b_state <= RESP_PEND;
            else if (bready) b_state <= RESP_IDLE; // no effect while idle.
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) bresp <= push ? RESP_OKAY : RESP_SLVERR;
    end

    // read side.
    assign ar_accept = arvalid && arready;
    assign rvalid    = (r_state == RESP_PEND);

    always_comb begin
        r_state_next = r_state;
        case (r_state)
            RESP_IDLE: if (ar_accept) r_state_next = RESP_PEND;
            RESP_PEND: if (rready) r_state_next = RESP_IDLE;
            default:   r_state_next = RESP_IDLE;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            r_state <= RESP_IDLE;
            arready <= 1'b0;
        end else begin
            r_state <= r_state_next;
            arready <= (r_state_next == RESP_IDLE); // free again once the response is taken.
        end
    end

    always_comb begin
        status_word = '0;
        status_word[STATUS_IDLE_BIT] = q_empty && synth_idle && ser_idle;
        status_word[COUNT_W-1:0] = bit_count;
    end

    always_ff @(posedge clk) begin
        if (ar_accept) begin
            rdata <= (araddr == STATUS_ADDR) ? status_word : 32'd0;
            rresp <= (araddr == STATUS_ADDR) ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// File: source/header_synthesis.sv
`timescale 1ns/1ps
`default_nettype none

module header_synthesis
    import huff_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  walk_event_t evt,
    input  wire         evt_valid,
    output logic        evt_ready,
    output code_word_t  cw,
    output logic        cw_valid,
    input  wire         cw_ready,
    output logic        synth_idle
);

    typedef enum logic [1:0] {WAIT, HOLD, EMIT} synth_state_e;

    synth_state_e state;
    synth_state_e state_next;
    code_word_t hold_q; // waits for the next event.
    code_word_t cw_q;
    logic evt_fire;
    logic is_finish;

    // leaf is 1 then the index, backtrack is a single 0.
    function automatic code_word_t form_word(input walk_event_t e);
        code_word_t w;
        w.last = 1'b0;
        if (e.op == OP_LEAF) begin
            w.bits = {1'b1, e.char_index};
            w.len  = LEAF_LEN;
        end else begin
            w.bits = '0;
            w.len  = BACKTRACK_LEN;
        end
        return w;
    endfunction

    assign evt_ready  = (state != EMIT);
    assign evt_fire   = evt_valid && evt_ready;
    assign is_finish  = (evt.op == OP_FINISH);
    assign cw         = cw_q;
    assign cw_valid   = (state == EMIT);
    assign synth_idle = (state == WAIT);

    always_comb begin
        state_next = state;
        case (state)
            WAIT:    if (evt_fire) state_next = is_finish ? EMIT : HOLD;
            HOLD:    if (evt_fire) state_next = EMIT;
            // a word without last leaves its successor in hold_q.
            EMIT:    if (cw_ready) state_next = cw_q.last ? WAIT : HOLD;
            default: state_next = WAIT;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) state <= WAIT;
        else state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (evt_fire) begin
            if (is_finish) begin
                if (state == HOLD) cw_q <= '{bits: hold_q.bits, len: hold_q.len, last: 1'b1};
                else cw_q <= '{bits: '0, len: BACKTRACK_LEN, last: 1'b1}; // lone closing 0.
            end else begin
                hold_q <= form_word(evt);
                if (state == HOLD) cw_q <= hold_q; // older word is not last.
            end
        end
    end

endmodule

`default_nettype wire

// File: source/bit_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module bit_serializer
    import huff_pkg::*;
#(
    parameter int COUNT_W = 16
) (
    input  wire                clk,
    input  wire                rst,
    input  code_word_t         cw,
    input  wire                cw_valid,
    output logic               cw_ready,
    output logic               hdr_bit,
    output logic               hdr_valid,
    output logic               hdr_last,
    input  wire                hdr_ready,
    output logic               ser_idle,
    output logic [COUNT_W-1:0] bit_count
);

    logic [CODE_W-1:0] shift_q;
    logic [3:0] remain_q; // bits left in the current word.
    logic last_q;
    logic busy_q;
    logic final_bit;
    logic bit_fire;
    logic load;

    assign final_bit = (remain_q == 4'd1);
    assign bit_fire  = busy_q && hdr_ready;

    // take the next word while the final bit goes out.
    assign cw_ready  = !busy_q || (hdr_ready && final_bit);
    assign load      = cw_valid && cw_ready;

    assign hdr_valid = busy_q;
    assign hdr_bit   = shift_q[CODE_W-1]; // msb first.
    assign hdr_last  = last_q && final_bit;
    assign ser_idle  = !busy_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            busy_q   <= 1'b0;
            remain_q <= '0;
            last_q   <= 1'b0;
        end else if (load) begin
            busy_q   <= 1'b1;
            remain_q <= cw.len;
            last_q   <= cw.last;
        end else if (bit_fire) begin
            remain_q <= remain_q - 1'b1;
            if (final_bit) busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) shift_q <= cw.bits;
        else if (bit_fire) shift_q <= {shift_q[CODE_W-2:0], 1'b0};
    end

    // running total for the status register, wraps.
    always_ff @(posedge clk, posedge rst) begin
        if (rst) bit_count <= '0;
        else if (bit_fire) bit_count <= bit_count + 1'b1;
    end

endmodule

`default_nettype wire

// File: source/huff_header_top.sv
`timescale 1ns/1ps
`default_nettype none

module huff_header_top
    import huff_pkg::*;
#(
    parameter int EVENT_DEPTH = 4,
    parameter int COUNT_W = 16
) (
    input  wire         clk,
    input  wire         rst,
    input  wire  [3:0]  awaddr,
    input  wire         awvalid,
    output logic        awready,
    input  wire  [31:0] wdata,
    input  wire         wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  wire         bready,
    input  wire  [3:0]  araddr,
    input  wire         arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  wire         rready,
    output logic        hdr_bit,
    output logic        hdr_valid,
    output logic        hdr_last,
    input  wire         hdr_ready
);

    walk_event_t evt;
    logic evt_valid;
    logic evt_ready;
    code_word_t cw;
    logic cw_valid;
    logic cw_ready;
    logic synth_idle;
    logic ser_idle;
    logic [COUNT_W-1:0] bit_count; // feeds the status word.

    walk_event_regs #(
        .EVENT_DEPTH (EVENT_DEPTH),
        .COUNT_W     (COUNT_W)
    ) u_regs (
        .clk        (clk),        .rst        (rst),
        .awaddr     (awaddr),     .awvalid    (awvalid),    .awready (awready),
        .wdata      (wdata),      .wvalid     (wvalid),     .wready  (wready),
        .bresp      (bresp),      .bvalid     (bvalid),     .bready  (bready),
        .araddr     (araddr),     .arvalid    (arvalid),    .arready (arready),
        .rdata      (rdata),      .rresp      (rresp),      .rvalid  (rvalid),
        .rready     (rready),
        .evt        (evt),        .evt_valid  (evt_valid),  .evt_ready (evt_ready),
        .synth_idle (synth_idle), .ser_idle   (ser_idle),   .bit_count (bit_count)
    );

    header_synthesis u_synth (
        .clk        (clk),
        .rst        (rst),
        .evt        (evt),
        .evt_valid  (evt_valid),
        .evt_ready  (evt_ready),
        .cw         (cw),
        .cw_valid   (cw_valid),
        .cw_ready   (cw_ready),
        .synth_idle (synth_idle)
    );

    bit_serializer #(
        .COUNT_W (COUNT_W)
    ) u_ser (
        .clk       (clk),
        .rst       (rst),
        .cw        (cw),
        .cw_valid  (cw_valid),
        .cw_ready  (cw_ready),
        .hdr_bit   (hdr_bit),
        .hdr_valid (hdr_valid),
        .hdr_last  (hdr_last),
        .hdr_ready (hdr_ready),
        .ser_idle  (ser_idle),
        .bit_count (bit_count)
    );

endmodule

`default_nettype wire

// File: testbench/huff_header_chk.sv
`timescale 1ns/1ps
`default_nettype none

module huff_header_chk (
    input wire clk,
    input wire rst,
    input wire bvalid,
    input wire bready,
    input wire rvalid,
    input wire rready,
    input wire hdr_bit,
    input wire hdr_valid,
    input wire hdr_last,
    input wire hdr_ready
);

    int fail_count = 0;

    // responses stay up until the host takes them.
    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
    else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
    else begin
        $error("rvalid dropped before rready");
        fail_count++;
    end

    stream_stall: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr_bit))
    else begin
        $error("header bit changed while the stream was stalled");
        fail_count++;
    end

    last_with_valid: assert property (@(posedge clk) disable iff (rst)
        hdr_last |-> hdr_valid)
    else begin
        $error("hdr_last raised without hdr_valid");
        fail_count++;
    end

endmodule

bind huff_header_top huff_header_chk chk0 (
    .clk       (clk),
    .rst       (rst),
    .bvalid    (bvalid),
    .bready    (bready),
    .rvalid    (rvalid),
    .rready    (rready),
    .hdr_bit   (hdr_bit),
    .hdr_valid (hdr_valid),
    .hdr_last  (hdr_last),
    .hdr_ready (hdr_ready)
);

`default_nettype wire

// File: testbench/huff_header_tb.sv
`timescale 1ns/1ps
`default_nettype none

module huff_header_tb
    import huff_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int COUNT_W = 16;
    localparam int WALK_LEN = 40;
    localparam int TOTAL_EVENTS = 5 + 7 + WALK_LEN + 6; // writes over all tests.
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_EVENTS + 1000;

    logic clk;
    logic rst;
    logic [3:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [3:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic hdr_bit;
    logic hdr_valid;
    logic hdr_last;
    logic hdr_ready;

    logic [15:0] stim_state = 16'd9;
    logic [15:0] gap_state = 16'd9; // separate stream for ready gaps.
    logic ready_random = 1'b0;
    logic use_random;
    logic exp_bits [$];
    logic exp_last [$];
    logic hdr_open = 1'b0; // a word waits for a possible finish.
    logic [COUNT_W-1:0] bits_total = '0;
    logic sink_bit;
    logic sink_last;
    logic [7:0] draw;
    walk_op_e walk_op;
    int error_count = 0;
    int stream_errors = 0;
    int test_mark = 0;
    int tests_failed = 0;

    huff_header_top #(
        .EVENT_DEPTH (4),
        .COUNT_W     (COUNT_W)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_state = lfsr_step(stim_state);
            v = {v[6:0], stim_state[0]};
        end
        return v;
    endfunction

    function automatic int total_errors();
        return error_count + stream_errors + dut0.chk0.fail_count;
    endfunction

    function automatic void push_bit(input logic b, input logic last);
        exp_bits.push_back(b);
        exp_last.push_back(last);
        bits_total = bits_total + 1'b1;
    endfunction

    // reference header encoding.
    function automatic void model_event(input walk_op_e op, input logic [7:0] idx);
        case (op)
            OP_LEAF: begin
                push_bit(1'b1, 1'b0);
                for (int i = 7; i >= 0; i--)
                    push_bit(idx[i], 1'b0);
                hdr_open = 1'b1;
            end
            OP_BACKTRACK: begin
                push_bit(1'b0, 1'b0);
                hdr_open = 1'b1;
            end
            default: begin
                if (hdr_open)
                    exp_last[exp_last.size() - 1] = 1'b1; // held word is still unsent.
                else
                    push_bit(1'b0, 1'b1);
                hdr_open = 1'b0;
            end
        endcase
    endfunction

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(posedge clk);
        while (!(awready && wready))
            @(posedge clk);
        #10;
        awvalid = 1'b0;
        wvalid = 1'b0;
        @(posedge clk);
        while (!bvalid)
            @(posedge clk);
        #10;
        bready = 1'b1; // response waits one cycle before it is taken.
        @(posedge clk);
        resp = bresp;
        #10;
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        araddr = addr;
        arvalid = 1'b1;
        @(posedge clk);
        while (!arready)
            @(posedge clk);
        #10;
        arvalid = 1'b0;
        @(posedge clk);
        while (!rvalid)
            @(posedge clk);
        #10;
        rready = 1'b1; // response waits one cycle before it is taken.
        @(posedge clk);
        data = rdata;
        resp = rresp;
        #10;
        rready = 1'b0;
    endtask

    task automatic post_event(input walk_op_e op, input logic [7:0] idx);
        logic [1:0] resp;
        model_event(op, idx);
        write_reg(EVENT_ADDR, {22'd0, op, idx}, resp);
        assert (resp == RESP_OKAY) else begin
            $display("[ERROR] bresp: expected %h, got %h", RESP_OKAY, resp);
            error_count++;
        end
    endtask

    // the model sees nothing of a rejected write.
    task automatic write_rejected(input logic [3:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        write_reg(addr, data, resp);
        assert (resp == RESP_SLVERR) else begin
            $display("[ERROR] bresp: expected %h, got %h", RESP_SLVERR, resp);
            error_count++;
        end
    endtask

    task automatic wait_drain();
        while (exp_bits.size() != 0) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic check_status();
        logic [31:0] data;
        logic [1:0] resp;
        read_reg(STATUS_ADDR, data, resp);
        assert (resp == RESP_OKAY) else begin
            $display("[ERROR] rresp: expected %h, got %h", RESP_OKAY, resp);
            error_count++;
        end
        assert (data[31] == 1'b1) else begin
            $display("[ERROR] rdata[31]: expected %h, got %h", 1'b1, data[31]);
            error_count++;
        end
        assert (data[15:0] == bits_total) else begin
            $display("[ERROR] rdata[15:0]: expected %h, got %h", bits_total, data[15:0]);
            error_count++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        int errs;
        wait_drain();
        check_status();
        errs = total_errors() - test_mark;
        test_mark = total_errors();
        if (errs != 0)
            tests_failed++;
        $display("test %0d, %s: %0d errors", num, name, errs);
    endtask

    // stream sink, compares every accepted bit.
    initial begin
        forever begin
            @(posedge clk);
            if (!rst && hdr_valid && hdr_ready) begin
                assert (exp_bits.size() != 0) else begin
                    $display("stream sent a header bit that the model does not expect");
                    stream_errors++;
                end
                if (exp_bits.size() != 0) begin
                    sink_bit = exp_bits.pop_front();
                    sink_last = exp_last.pop_front();
                    assert (hdr_bit == sink_bit) else begin
                        $display("[ERROR] hdr_bit: expected %h, got %h", sink_bit, hdr_bit);
                        stream_errors++;
                    end
                    assert (hdr_last == sink_last) else begin
                        $display("[ERROR] hdr_last: expected %h, got %h", sink_last, hdr_last);
                        stream_errors++;
                    end
                end
            end
        end
    end

    initial begin
        hdr_ready = 1'b1;
        forever begin
            @(posedge clk);
            use_random = ready_random;
            #10;
            if (use_random) begin
                gap_state = lfsr_step(gap_state);
                hdr_ready = gap_state[0];
            end else begin
                hdr_ready = 1'b1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the header stream did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;

        for (int i = 0; i < 4; i++)
            post_event(OP_LEAF, rand_bits(8));
        post_event(OP_FINISH, 8'h00);
        finish_test(1, "leaf headers");

        post_event(OP_LEAF, rand_bits(8));
        post_event(OP_BACKTRACK, rand_bits(8)); // index is ignored.
        post_event(OP_LEAF, rand_bits(8));
        post_event(OP_BACKTRACK, rand_bits(8));
        post_event(OP_BACKTRACK, rand_bits(8));
        post_event(OP_FINISH, 8'h00);
        post_event(OP_FINISH, 8'h00); // nothing pending, lone 0.
        finish_test(2, "backtrack zeros");

        ready_random = 1'b1;
        for (int i = 0; i < WALK_LEN; i++) begin
            draw = rand_bits(2);
            case (draw[1:0])
                2'd1:    walk_op = OP_BACKTRACK;
                2'd2:    walk_op = OP_FINISH;
                default: walk_op = OP_LEAF;
            endcase
            if (i == WALK_LEN - 1)
                walk_op = OP_FINISH;
            post_event(walk_op, rand_bits(8));
        end
        finish_test(3, "back-pressure walk");
        ready_random = 1'b0;

        post_event(OP_LEAF, rand_bits(8));
        write_rejected(EVENT_ADDR, {22'd0, OP_ILLEGAL, rand_bits(8)});
        post_event(OP_BACKTRACK, 8'h00);
        write_rejected(4'h8, {22'd0, OP_LEAF, rand_bits(8)});
        post_event(OP_LEAF, rand_bits(8));
        post_event(OP_FINISH, 8'h00);
        finish_test(4, "illegal writes");

        begin
            logic [31:0] data;
            logic [1:0] resp;
            read_reg(4'hC, data, resp);
            assert (resp == RESP_SLVERR) else begin
                $display("[ERROR] rresp: expected %h, got %h", RESP_SLVERR, resp);
                error_count++;
            end
            assert (data == 32'd0) else begin
                $display("[ERROR] rdata: expected %h, got %h", 32'd0, data);
                error_count++;
            end
        end
        finish_test(5, "status read");

        $display("tests run: 5, tests failed: %0d, errors: %0d", tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
source/huff_pkg.sv
source/walk_event_regs.sv
source/header_synthesis.sv
source/bit_serializer.sv
source/huff_header_top.sv
testbench/huff_header_chk.sv
testbench/huff_header_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = huff_header_tb
FILELIST  = src.f

.PHONY: sim clean

# the run passes only if the pass line shows up in the output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
